// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module tb_sweep
	verilator --lint-only verilog/sweep_pkg.sv verilog/tone_source.sv \
		verilog/crossing_detect.sv verilog/sweep_sequencer.sv verilog/phase_meter.sv \
		verilog/result_port.sv verilog/sweep_top.sv --top-module sweep_top

sim:
	verilator --binary --timing -f filelist.f --top-module tb_sweep -Mdir obj_dir
	out="$$(./obj_dir/Vtb_sweep)"; echo "$$out"; \
		echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
verilog/sweep_pkg.sv
verilog/tone_source.sv
verilog/crossing_detect.sv
verilog/sweep_sequencer.sv
verilog/phase_meter.sv
verilog/result_port.sv
verilog/sweep_top.sv
verif/sweep_model.sv
verif/tb_sweep.sv

// ==== freq_table.hex ====
// phase increment per sweep point, one 32-bit hex word per line
01480000
01600000
01800000
01a00000
01c00000
01e00000
02000000
02400000
02800000
02c00000
03000000
03800000
04000000
04800000
05000000
06000000

// ==== verif/sweep_model.sv ====
module sweep_model (
  input  logic               clk125,
  input  sweep_pkg::sample_t stim_sample,
  input  logic               result_req,
  output int                 period_errors,
  output int                 period_checks
);
  timeunit 1ns;
  timeprecision 1ps;
  import sweep_pkg::*;

  logic [phase_w-1:0] inc_rom [point_count];
  int   cur_point   = 0;  // point whose tone is being checked
  int   falls_since = 0;  // falls seen since the last point change
  int   last_fall   = 0;
  int   cycle_cnt   = 0;
  logic prev_neg    = 1'b0;
  logic prev_req    = 1'b0;

  initial
  begin
    period_errors = 0;
    period_checks = 0;
    $readmemh(freq_file, inc_rom);
  end

  // the first two falls after a step may mix old and new increments
  always @(negedge clk125)
  begin
    longint interval;
    longint diff;
    cycle_cnt = cycle_cnt + 1;
    if (result_req && !prev_req)
    begin
      cur_point   = cur_point + 1;
      falls_since = 0;
    end
    if (!prev_neg && stim_sample[sample_w-1])
    begin
      falls_since = falls_since + 1;
      if (falls_since >= 3 && cur_point < point_count)
      begin
        interval = longint'(cycle_cnt - last_fall);
        diff     = interval * longint'(inc_rom[cur_point]) - (64'sd1 <<< phase_w);
        period_checks = period_checks + 1;
        if (diff > longint'(inc_rom[cur_point]) || diff < -longint'(inc_rom[cur_point]))
        begin
          $display("[ERROR] stim_sample period at point 0x%h: got 0x%h cycles, increment 0x%h",
                   cur_point, interval, inc_rom[cur_point]);
          period_errors = period_errors + 1;
        end
      end
      last_fall = cycle_cnt;
    end
    prev_neg = stim_sample[sample_w-1];
    prev_req = result_req;
  end

endmodule

// ==== verif/tb_sweep.sv ====
module tb_sweep;
  timeunit 1ns;
  timeprecision 1ps;
  import sweep_pkg::*;

  localparam int ack_max     = 50;
  localparam int cycle_limit = point_count * (settle_cycles + meas_cycles + 2) * 256
                               + point_count * ack_max + 1000;

  logic         clk125 = 1'b0;
  logic         areset_n;
  logic         start;
  logic         result_ack;
  sample_t      adc_a = '0;
  sample_t      adc_b = '0;
  sample_t      stim_sample;
  logic         busy;
  logic         sweep_done;
  logic         result_req;
  meas_result_t result;

  int cycle = 0;
  int errors = 0;
  int results_done = 0;
  int period_errors;
  int period_checks;
  int exp_a [point_count];
  int exp_b [point_count];
  int exp_d [point_count];

  // waveform now driven on adc_a and adc_b
  logic wave_on = 1'b0;
  int   t0 = 0;
  int   per_w = 40;
  int   amp_a_w = 1;
  int   amp_b_w = 1;
  int   dly_w = 0;

  sweep_top sweep_top_i (.*);

  sweep_model sweep_model_i (.clk125, .stim_sample, .result_req, .period_errors, .period_checks);

  always #50 clk125 = ~clk125;

  always @(posedge clk125)
  begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit)
    begin
      $display("timeout: the sweep did not finish within %0d cycles", cycle_limit);
      $display("errors: results %0d, periods %0d", errors, period_errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic sample_t square_level(int t, int from, int per, int amp);
    if (t < from)
      return sample_t'(-amp);
    if (((t - from) % per) < per / 2)
      return sample_t'(amp);
    return sample_t'(-amp);
  endfunction

  // the leading channel starts first, so crossings pair up from the start
  always @(negedge clk125)
  begin
    if (!wave_on)
    begin
      adc_a <= sample_t'(-amp_a_w);
      adc_b <= sample_t'(-amp_b_w);
    end
    else
    begin
      adc_a <= square_level(cycle, t0 + (dly_w < 0 ? -dly_w : 0), per_w, amp_a_w);
      adc_b <= square_level(cycle, t0 + (dly_w > 0 ? dly_w : 0), per_w, amp_b_w);
    end
  end

  task automatic pick_waveform(input int k);
    int per;
    int dmax;
    begin
      per      = $urandom_range(120, 40);
      dmax     = per / 2 - 5;
      exp_a[k] = $urandom_range(8000, 1);
      exp_b[k] = $urandom_range(8000, 1);
      exp_d[k] = int'($urandom_range(2 * dmax, 0)) - dmax;
      wave_on <= 1'b0;
      per_w   <= per;
      amp_a_w <= exp_a[k];
      amp_b_w <= exp_b[k];
      dly_w   <= exp_d[k];
    end
  endtask

  task automatic wait_req_rise();
    begin
      @(negedge clk125);
      while (result_req)
        @(negedge clk125);
      while (!result_req)
        @(negedge clk125);
    end
  endtask

  task automatic count_stim_falls(input int n);
    int   seen;
    logic was_neg;
    begin
      seen = 0;
      @(negedge clk125);
      was_neg = stim_sample[sample_w-1];
      while (seen < n)
      begin
        @(negedge clk125);
        if (!was_neg && stim_sample[sample_w-1])
          seen++;
        was_neg = stim_sample[sample_w-1];
      end
    end
  endtask

  task automatic check_field(input string name, input int got, input int expected);
    begin
      if (got != expected)
      begin
        $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, expected);
        errors++;
      end
    end
  endtask

  task automatic check_stable(input meas_result_t held);
    begin
      if (result != held)
      begin
        $display("[ERROR] result: got 0x%h expected 0x%h", result, held);
        errors++;
      end
    end
  endtask

  initial
  begin
    void'($urandom(25));
    start      = 1'b0;
    result_ack = 1'b0;
    areset_n   = 1'b0;
    repeat (3) @(posedge clk125);
    @(negedge clk125);
    areset_n = 1'b1;
    repeat (5)
    begin
      @(negedge clk125);
      check_field("result_req", int'(result_req), 0);
      check_field("busy", int'(busy), 0);
      check_field("sweep_done", int'(sweep_done), 0);
    end
    for (int k = 0; k < point_count; k++)
    begin
      if (k == 0)
      begin
        pick_waveform(k);
        @(negedge clk125);
        start = 1'b1;
      end
      else
      begin
        wait_req_rise();
        pick_waveform(k);
      end
      count_stim_falls(settle_cycles);  // launch is past by now
      repeat (3) @(negedge clk125);
      wave_on <= 1'b1;
      t0      <= cycle;
    end
    while (results_done < point_count)
      @(negedge clk125);
    repeat (10)
    begin
      @(negedge clk125);
      check_field("sweep_done", int'(sweep_done), 1);
      check_field("busy", int'(busy), 0);
    end
    start = 1'b0;
    repeat (3) @(negedge clk125);
    check_field("sweep_done", int'(sweep_done), 0);
    repeat (200)
    begin
      @(negedge clk125);
      if (result_req)
      begin
        $display("result_req rose again after the last point of the sweep");
        errors++;
      end
    end
    if (period_checks == 0)
    begin
      $display("no stimulus period was measured during the sweep");
      errors++;
    end
    $display("errors: results %0d, periods %0d", errors, period_errors);
    if (errors == 0 && period_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // takes each result and answers with a random ack delay
  initial
  begin
    meas_result_t held;
    int wait_cycles;
    @(posedge areset_n);
    for (int n = 0; n < point_count; n++)
    begin
      @(negedge clk125);
      while (!result_req)
        @(negedge clk125);
      held = result;
      check_field("result.point", int'(result.point), n);
      check_field("result.peak_a", int'(result.peak_a), exp_a[n]);
      check_field("result.peak_b", int'(result.peak_b), exp_b[n]);
      check_field("result.phase", int'(result.phase), int'(delay_t'(exp_d[n])));
      // busy drops and sweep_done rises with the last result
      check_field("busy", int'(busy), int'(n < point_count - 1));
      check_field("sweep_done", int'(sweep_done), int'(n == point_count - 1));
      wait_cycles = $urandom_range(ack_max, 0);
      repeat (wait_cycles)
      begin
        @(negedge clk125);
        check_field("result_req", int'(result_req), 1);
        check_stable(held);
      end
      result_ack = 1'b1;
      @(negedge clk125);
      check_field("result_req", int'(result_req), 0);  // one cycle after ack
      result_ack = 1'b0;
      results_done = n + 1;
    end
  end

endmodule

// ==== verilog/crossing_detect.sv ====
module crossing_detect (
  input  logic               clk125,
  input  logic               areset_n,
  input  sweep_pkg::sample_t sample,
  output logic               crossing
);
  import sweep_pkg::*;

  logic [detect_cnt_w-1:0] run_cnt;  // consecutive non-negative samples
  logic                    armed;
  logic                    negative;

  assign negative = sample[$bits(sample)-1];

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      run_cnt  <= '0;
      armed    <= 1'b0;
      crossing <= 1'b0;
    end
    else
    begin
      crossing <= 1'b0;
      if (!negative)
      begin
        if (!armed)
        begin
          // arm on the detect_len-th sample of the run
          if (run_cnt == detect_cnt_w'(detect_len - 1))
          begin
            armed   <= 1'b1;
            run_cnt <= '0;
          end
          else
            run_cnt <= run_cnt + 1'b1;
        end
      end
      else
      begin
        run_cnt <= '0;
        if (armed)
        begin
          crossing <= 1'b1;  // first negative after a long enough run
          armed    <= 1'b0;
        end
      end
    end
  end

  // short positive glitches never arm, so noise near zero
  // gives at most one pulse per falling edge

endmodule

// ==== verilog/phase_meter.sv ====
module phase_meter (
  input  logic                    clk125,
  input  logic                    areset_n,
  input  sweep_pkg::meas_cmd_t    cmd,
  input  sweep_pkg::sample_t      adc_a,
  input  sweep_pkg::sample_t      adc_b,
  input  logic                    cross_a,
  input  logic                    cross_b,
  input  logic                    port_busy,
  output logic                    meas_done,
  output sweep_pkg::meas_result_t meas
);
  import sweep_pkg::*;

  // which channel crossed first in the current pair
  typedef enum logic [1:0]
  {
    lead_none,
    lead_a,
    lead_b
  } lead_t;

  lead_t                 lead;
  lead_t                 lead_next;
  logic                  active;    // window open
  logic                  pending;   // result waiting for the port
  logic [meas_cnt_w-1:0] a_cnt;
  logic                  close;
  delay_t                dly_cnt;
  logic                  restart;   // start a new delay count
  logic                  latch_en;
  delay_t                latch_val;

  assign close = active && cross_a && (a_cnt == meas_cnt_w'(meas_cycles - 1));

  // pair up crossings of A and B
  always_comb
  begin
    lead_next = lead;
    restart   = 1'b0;
    latch_en  = 1'b0;
    latch_val = dly_cnt;
    case (lead)
      lead_none:
      begin
        if (cross_a && cross_b)
        begin
          latch_en  = 1'b1;
          latch_val = '0;  // coincident crossings
        end
        else if (cross_a || cross_b)
        begin
          lead_next = cross_a ? lead_a : lead_b;
          restart   = 1'b1;
        end
      end
      lead_a:
      begin
        if (cross_b)
        begin
          latch_en  = 1'b1;
          lead_next = lead_none;
        end
        else if (cross_a)
          restart = 1'b1;  // A again before B, take the newer one
      end
      lead_b:
      begin
        if (cross_a)
        begin
          latch_en  = 1'b1;
          latch_val = -dly_cnt;  // B leads, negative delay
          lead_next = lead_none;
        end
        else if (cross_b)
          restart = 1'b1;
      end
      default: lead_next = lead_none;
    endcase
  end

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      active    <= 1'b0;
      pending   <= 1'b0;
      a_cnt     <= '0;
      lead      <= lead_none;
      meas_done <= 1'b0;
    end
    else
    begin
      meas_done <= 1'b0;
      if (cmd.launch)
      begin
        active <= 1'b1;
        a_cnt  <= '0;
        lead   <= lead_none;
      end
      else if (active)
      begin
        lead <= lead_next;
        if (close)
          active <= 1'b0;
        else if (cross_a)
          a_cnt <= a_cnt + 1'b1;
      end
      // done waits here while the port still holds the last result
      if (close)
      begin
        if (port_busy)
          pending <= 1'b1;
        else
          meas_done <= 1'b1;
      end
      else if (pending && !port_busy)
      begin
        pending   <= 1'b0;
        meas_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk125)
  begin
    if (cmd.launch)
    begin
      meas.point  <= cmd.point;
      meas.peak_a <= '0;
      meas.peak_b <= '0;
      meas.phase  <= '0;
    end
    else if (active)
    begin
      if (adc_a > meas.peak_a)
        meas.peak_a <= adc_a;
      if (adc_b > meas.peak_b)
        meas.peak_b <= adc_b;
      if (latch_en)
        meas.phase <= latch_val;
      dly_cnt <= restart ? delay_t'(1) : dly_cnt + 1'b1;
    end
  end

endmodule

// ==== verilog/result_port.sv ====
module result_port (
  input  logic                    clk125,
  input  logic                    areset_n,
  input  logic                    meas_done,
  input  sweep_pkg::meas_result_t meas,
  input  logic                    result_ack,
  output logic                    port_busy,
  output logic                    result_req,
  output sweep_pkg::meas_result_t result
);

  // four-phase handshake, busy until ack has returned low
  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      result_req <= 1'b0;
      port_busy  <= 1'b0;
    end
    else
    begin
      if (meas_done)
      begin
        result_req <= 1'b1;
        port_busy  <= 1'b1;
      end
      else if (result_req)
      begin
        if (result_ack)
          result_req <= 1'b0;  // drop the cycle after ack
      end
      else if (port_busy && !result_ack)
        port_busy <= 1'b0;
    end
  end

  // captured once, then held for the whole transfer
  always_ff @(posedge clk125)
  begin
    if (meas_done)
      result <= meas;
  end

endmodule

// ==== verilog/sweep_pkg.sv ====
package sweep_pkg;

  // converter and accumulator widths
  localparam int sample_w = 14;
  localparam int phase_w  = 32;
  localparam int delay_w  = 16;

  // sweep and measurement counts
  localparam int point_count   = 16;
  localparam int detect_len    = 8;  // non-negative run needed to arm
  localparam int settle_cycles = 4;  // stimulus crossings after a step
  localparam int meas_cycles   = 4;  // A crossings per window

  localparam string freq_file = "freq_table.hex";

  // counter widths
  localparam int detect_cnt_w = $clog2(detect_len);
  localparam int settle_cnt_w = $clog2(settle_cycles);
  localparam int meas_cnt_w   = $clog2(meas_cycles);

  typedef logic signed [sample_w-1:0] sample_t;
  typedef logic [$clog2(point_count)-1:0] point_t;
  typedef logic signed [delay_w-1:0] delay_t;

  // one finished measurement, 48 bits
  typedef struct packed
  {
    point_t  point;
    sample_t peak_a;
    sample_t peak_b;
    delay_t  phase;
  } meas_result_t;

  // sequencer to meter
  typedef struct packed
  {
    logic   launch;
    point_t point;
  } meas_cmd_t;

endpackage

// ==== verilog/sweep_sequencer.sv ====
module sweep_sequencer (
  input  logic                 clk125,
  input  logic                 areset_n,
  input  logic                 start,
  input  logic                 stim_crossing,
  input  logic                 meas_done,
  output sweep_pkg::point_t    point,
  output sweep_pkg::meas_cmd_t cmd,
  output logic                 busy,
  output logic                 sweep_done
);
  import sweep_pkg::*;

  typedef enum logic [1:0]
  {
    st_idle,
    st_settle,
    st_measure,
    st_done
  } seq_state_t;

  seq_state_t              state;
  logic [settle_cnt_w-1:0] settle_cnt;
  logic                    launch;

  assign cmd = '{launch: launch, point: point};

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state      <= st_idle;
      point      <= '0;
      settle_cnt <= '0;
      launch     <= 1'b0;
      busy       <= 1'b0;
      sweep_done <= 1'b0;
    end
    else
    begin
      launch <= 1'b0;
      case (state)
        st_idle:
        begin
          if (start)
          begin
            state      <= st_settle;
            point      <= '0;
            settle_cnt <= '0;
            busy       <= 1'b1;
          end
        end
        st_settle:
        begin
          if (stim_crossing)
          begin
            if (settle_cnt == settle_cnt_w'(settle_cycles - 1))
            begin
              launch <= 1'b1;  // tone has settled at this point
              state  <= st_measure;
            end
            else
              settle_cnt <= settle_cnt + 1'b1;
          end
        end
        st_measure:
        begin
          // meter latency varies, wait for its done pulse
          if (meas_done)
          begin
            if (point == point_t'(point_count - 1))
            begin
              state      <= st_done;
              busy       <= 1'b0;
              sweep_done <= 1'b1;
            end
            else
            begin
              point      <= point + 1'b1;
              settle_cnt <= '0;
              state      <= st_settle;
            end
          end
        end
        st_done:
        begin
          if (!start)
          begin
            state      <= st_idle;
            sweep_done <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== verilog/sweep_top.sv ====
module sweep_top (
  input  logic                    clk125,
  input  logic                    areset_n,
  input  logic                    start,
  input  sweep_pkg::sample_t      adc_a,
  input  sweep_pkg::sample_t      adc_b,
  input  logic                    result_ack,
  output sweep_pkg::sample_t      stim_sample,
  output logic                    busy,
  output logic                    sweep_done,
  output logic                    result_req,
  output sweep_pkg::meas_result_t result
);
  import sweep_pkg::*;

  sample_t      adc_a_q;
  sample_t      adc_b_q;
  point_t       point;
  meas_cmd_t    cmd;
  meas_result_t meas;
  logic         cross_s;
  logic         cross_a;
  logic         cross_b;
  logic         meas_done;
  logic         port_busy;

  // one register stage on both channels keeps A and B aligned
  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end
    else
    begin
      adc_a_q <= adc_a;
      adc_b_q <= adc_b;
    end
  end

  tone_source tone_source_i (.clk125, .areset_n, .point, .stim_sample);

  crossing_detect stim_detect_i (.clk125, .areset_n, .sample(stim_sample), .crossing(cross_s));
  crossing_detect a_detect_i (.clk125, .areset_n, .sample(adc_a_q), .crossing(cross_a));
  crossing_detect b_detect_i (.clk125, .areset_n, .sample(adc_b_q), .crossing(cross_b));

  sweep_sequencer sweep_sequencer_i (
    .clk125, .areset_n, .start, .stim_crossing(cross_s), .meas_done,
    .point, .cmd, .busy, .sweep_done
  );

  phase_meter phase_meter_i (
    .clk125, .areset_n, .cmd, .adc_a(adc_a_q), .adc_b(adc_b_q),
    .cross_a, .cross_b, .port_busy, .meas_done, .meas
  );

  result_port result_port_i (
    .clk125, .areset_n, .meas_done, .meas, .result_ack,
    .port_busy, .result_req, .result
  );

endmodule

// ==== verilog/tone_source.sv ====
module tone_source (
  input  logic               clk125,
  input  logic               areset_n,
  input  sweep_pkg::point_t  point,
  output sweep_pkg::sample_t stim_sample
);
  import sweep_pkg::*;

  logic [phase_w-1:0] freq_rom [point_count];
  logic [phase_w-1:0] phase_inc;
  logic [phase_w-1:0] phase_acc;

  initial
  begin
    $readmemh(freq_file, freq_rom);
  end

  // increment follows point one cycle later
  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      phase_inc <= '0;
      phase_acc <= '0;
    end
    else
    begin
      phase_inc <= freq_rom[point];
      phase_acc <= phase_acc + phase_inc;
    end
  end

  // top bits as signed give a sawtooth, one sign change per period
  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
      stim_sample <= '0;
    else
      stim_sample <= sample_t'(phase_acc[phase_w-1 -: sample_w]);
  end

endmodule
